// File: source/debug_pkg.sv
package debug_pkg;

	//////////////////////////////////////////////////////////////////////
	// Command bytes
	//////////////////////////////////////////////////////////////////////

	// 'A' single-steps the core, 'B' dumps data memory
	localparam logic [7:0] CMD_STEP     = 8'h41;
	localparam logic [7:0] CMD_MEM_DUMP = 8'h42;

	//////////////////////////////////////////////////////////////////////
	// Serial link and buffering
	//////////////////////////////////////////////////////////////////////

	// Kept short for simulation, retune for the board clock
	localparam int CLKS_PER_BIT = 16;

	localparam int FIFO_DEPTH  = 16;
	localparam int FIFO_ADDR_W = 4;

	//////////////////////////////////////////////////////////////////////
	// Processor side
	//////////////////////////////////////////////////////////////////////

	localparam int MEM_DUMP_WORDS = 21;
	localparam int MEM_ADDR_W     = 5;
	localparam int WORD_BYTES     = 4;

	// Field order is also the send order
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
		logic [31:0] alu_result;
		logic [31:0] mem_data;
	} cpu_snapshot_t;

	localparam int SNAPSHOT_BYTES = 16;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rxd,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef logic [$clog2(debug_pkg::CLKS_PER_BIT)-1:0] cnt_t;

	rx_state_t  state;
	cnt_t       clk_cnt;
	logic [2:0] bit_cnt;
	logic [1:0] rx_sync;
	logic       rx_prev;
	logic [7:0] shift;
	logic       bit_end;

	// Two flops against metastability
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_sync <= {rx_sync[0], rxd};
			rx_prev <= rx_sync[1];
		end
	end

	assign bit_end = (clk_cnt == cnt_t'(debug_pkg::CLKS_PER_BIT - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync[1])
						state <= RX_START;
				end
				// Half a bit in, start bit must still be low
				RX_START:
				begin
					if (clk_cnt == cnt_t'(debug_pkg::CLKS_PER_BIT / 2 - 1))
					begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					if (bit_end)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_sync[1], shift[7:1]};
	end

	assign rx_byte  = shift;
	assign rx_valid = (state == RX_STOP) && bit_end && rx_sync[1];

endmodule

// File: source/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] dout,
	input  logic       empty,
	output logic       pop,
	output logic       txd
);

	typedef logic [$clog2(debug_pkg::CLKS_PER_BIT)-1:0] cnt_t;

	logic       busy;
	cnt_t       clk_cnt;
	logic [3:0] bit_cnt;
	logic [9:0] frame;
	logic       bit_end;
	logic       frame_end;

	assign bit_end   = (clk_cnt == cnt_t'(debug_pkg::CLKS_PER_BIT - 1));
	assign frame_end = busy && bit_end && (bit_cnt == 4'd9);

	// Back to back frames when the FIFO still holds data
	assign pop = (!busy || frame_end) && !empty;
	assign txd = busy ? frame[0] : 1'b1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (pop)
		begin
			busy    <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (busy)
		begin
			clk_cnt <= clk_cnt + 1'b1;
			if (bit_end)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd9)
					busy <= 1'b0;
			end
		end
	end

	// Stop, data, start
	always_ff @(posedge clk)
	begin
		if (pop)
			frame <= {1'b1, dout, 1'b0};
		else if (busy && bit_end)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  logic [7:0] push_byte,
	input  logic       pop,
	output logic [7:0] dout,
	output logic       full,
	output logic       empty
);

	typedef logic [debug_pkg::FIFO_ADDR_W-1:0] ptr_t;
	typedef logic [debug_pkg::FIFO_ADDR_W:0]   count_t;

	logic [7:0] mem [debug_pkg::FIFO_DEPTH];
	ptr_t       wr_ptr;
	ptr_t       rd_ptr;
	count_t     count;
	logic       do_push;
	logic       do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (count == count_t'(debug_pkg::FIFO_DEPTH));
	assign empty = (count == '0);
	assign dout  = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_byte;
	end

	// Pointers wrap on their own at the power of two depth
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: source/dump_sequencer.sv
`timescale 1ns/10ps

module dump_sequencer (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [7:0]                          rx_byte,
	input  logic                                rx_valid,
	input  debug_pkg::cpu_snapshot_t            snapshot,
	input  logic [31:0]                         mem_rdata,
	input  logic                                full,
	output logic                                push,
	output logic [7:0]                          push_byte,
	output logic                                step,
	output logic                                debug_mode,
	output logic [debug_pkg::MEM_ADDR_W-1:0]    mem_addr,
	output logic                                mem_read
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_STEP,
		S_CAPTURE,
		S_SEND_SNAP,
		S_READ,
		S_LATCH,
		S_SEND_WORD,
		S_DONE
	} state_t;

	typedef logic [$clog2(debug_pkg::SNAPSHOT_BYTES)-1:0] idx_t;
	typedef logic [debug_pkg::MEM_ADDR_W-1:0]             addr_t;

	state_t                   state;
	idx_t                     byte_idx;
	addr_t                    word_addr;
	debug_pkg::cpu_snapshot_t snap_q;
	logic [31:0]              word_q;
	logic [31:0]              sel_word;
	logic                     sending;
	logic                     last_byte;

	//////////////////////////////////////////////////////////////////////
	// Byte serializer
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		sending = (state == S_SEND_SNAP) || (state == S_SEND_WORD);
		if (state == S_SEND_WORD)
		begin
			sel_word  = word_q;
			last_byte = (byte_idx[1:0] == 2'(debug_pkg::WORD_BYTES - 1));
		end
		else
		begin
			case (byte_idx[3:2])
				2'd0:    sel_word = snap_q.pc;
				2'd1:    sel_word = snap_q.instruction;
				2'd2:    sel_word = snap_q.alu_result;
				default: sel_word = snap_q.mem_data;
			endcase
			last_byte = (byte_idx == idx_t'(debug_pkg::SNAPSHOT_BYTES - 1));
		end
	end

	// Least significant byte goes out first
	assign push_byte = sel_word[8 * byte_idx[1:0] +: 8];
	assign push      = sending && !full;

	// Processor side strobes straight from the state
	assign step       = (state == S_STEP);
	assign mem_read   = (state == S_READ);
	assign debug_mode = (state == S_READ) || (state == S_LATCH) || (state == S_SEND_WORD);
	assign mem_addr   = word_addr;

	//////////////////////////////////////////////////////////////////////
	// Command FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= S_IDLE;
			byte_idx  <= '0;
			word_addr <= '0;
		end
		else
		begin
			case (state)
				// Unknown bytes fall through here
				S_IDLE:
				begin
					byte_idx  <= '0;
					word_addr <= '0;
					if (rx_valid && rx_byte == debug_pkg::CMD_STEP)
						state <= S_STEP;
					else if (rx_valid && rx_byte == debug_pkg::CMD_MEM_DUMP)
						state <= S_READ;
				end
				S_STEP:    state <= S_CAPTURE;
				// Core has advanced, snapshot is taken this cycle
				S_CAPTURE: state <= S_SEND_SNAP;
				S_SEND_SNAP:
				begin
					if (push)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (last_byte)
							state <= S_DONE;
					end
				end
				S_READ:  state <= S_LATCH;
				S_LATCH: state <= S_SEND_WORD;
				S_SEND_WORD:
				begin
					if (push)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (last_byte)
						begin
							byte_idx <= '0;
							if (word_addr == addr_t'(debug_pkg::MEM_DUMP_WORDS - 1))
								state <= S_DONE;
							else
							begin
								word_addr <= word_addr + 1'b1;
								state     <= S_READ;
							end
						end
					end
				end
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Registered read, data is there one cycle after the strobe
	always_ff @(posedge clk)
	begin
		if (state == S_CAPTURE)
			snap_q <= snapshot;
		if (state == S_LATCH)
			word_q <= mem_rdata;
	end

endmodule

// File: source/uart_debug_unit.sv
`timescale 1ns/10ps

module uart_debug_unit (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             rxd,
	output logic                             txd,
	input  debug_pkg::cpu_snapshot_t         snapshot,
	input  logic [31:0]                      mem_rdata,
	output logic                             step,
	output logic                             debug_mode,
	output logic [debug_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic                             mem_read
);

	logic [7:0] rx_byte;
	logic       rx_valid;
	logic [7:0] push_byte;
	logic       push;
	logic [7:0] dout;
	logic       pop;
	logic       full;
	logic       empty;

	uart_rx i_uart_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.rxd      (rxd),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	dump_sequencer i_dump_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.snapshot   (snapshot),
		.mem_rdata  (mem_rdata),
		.full       (full),
		.push       (push),
		.push_byte  (push_byte),
		.step       (step),
		.debug_mode (debug_mode),
		.mem_addr   (mem_addr),
		.mem_read   (mem_read)
	);

	// Absorbs the gap between dump speed and line rate
	byte_fifo i_byte_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_byte (push_byte),
		.pop       (pop),
		.dout      (dout),
		.full      (full),
		.empty     (empty)
	);

	uart_tx i_uart_tx (
		.clk   (clk),
		.rst_n (rst_n),
		.dout  (dout),
		.empty (empty),
		.pop   (pop),
		.txd   (txd)
	);

endmodule

// File: bench/uart_debug_unit_sva.sv
`timescale 1ns/10ps

module dump_sequencer_sva (
	input logic       clk,
	input logic       rst_n,
	input logic [7:0] rx_byte,
	input logic       rx_valid,
	input logic       step,
	input logic       mem_read,
	input logic       debug_mode,
	input logic       sending,
	input logic       full,
	input logic [7:0] push_byte
);

	// Step is a clock enable for one core cycle, started only by an 'A'
	step_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		step |-> !$past(step) && $past(rx_valid && rx_byte == debug_pkg::CMD_STEP))
		else $error("step was not a single pulse after a step command");

	// Memory port stays with the debug unit while the read data is latched
	read_in_debug_mode: assert property (@(posedge clk) disable iff (!rst_n)
		mem_read |=> debug_mode && !mem_read)
		else $error("debug_mode dropped or mem_read stayed high after a read");

	// A byte held back by a full FIFO is offered again unchanged
	stall_holds_byte: assert property (@(posedge clk) disable iff (!rst_n)
		sending && full |=> sending && $stable(push_byte))
		else $error("the byte offered to a full FIFO changed or was dropped");

endmodule

bind dump_sequencer dump_sequencer_sva i_dump_sequencer_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.rx_byte    (rx_byte),
	.rx_valid   (rx_valid),
	.step       (step),
	.mem_read   (mem_read),
	.debug_mode (debug_mode),
	.sending    (sending),
	.full       (full),
	.push_byte  (push_byte)
);

// File: bench/tb_uart_debug_unit.sv
`timescale 1ns/10ps

module tb_uart_debug_unit;

	localparam int CLK_PERIOD = 40;
	localparam int BIT_CLKS   = debug_pkg::CLKS_PER_BIT;
	localparam int DUMP_BYTES = debug_pkg::MEM_DUMP_WORDS * debug_pkg::WORD_BYTES;
	// Frames per test, idle windows rounded up to whole frames
	localparam int TEST_BYTES = 2 + 17 + 21 + (1 + DUMP_BYTES) + (7 + DUMP_BYTES);
	localparam longint WATCHDOG_NS = 2 * TEST_BYTES * 10 * BIT_CLKS * CLK_PERIOD;

	logic                             clk;
	logic                             rst_n;
	logic                             rxd;
	logic                             txd;
	debug_pkg::cpu_snapshot_t         snapshot = '0;
	logic [31:0]                      mem_rdata = '0;
	logic                             step;
	logic                             debug_mode;
	logic [debug_pkg::MEM_ADDR_W-1:0] mem_addr;
	logic                             mem_read;

	integer                           seed = 32'ha16f;
	int                               step_count = 0;
	int                               debug_cycles = 0;
	debug_pkg::cpu_snapshot_t         exp_snap = '0;
	logic                             step_seen = 1'b0;
	logic                             read_pending = 1'b0;
	logic [debug_pkg::MEM_ADDR_W-1:0] read_addr = '0;
	logic [31:0]                      mem_words [debug_pkg::MEM_DUMP_WORDS];
	logic [7:0]                       got_bytes [$];

	uart_debug_unit i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.rxd        (rxd),
		.txd        (txd),
		.snapshot   (snapshot),
		.mem_rdata  (mem_rdata),
		.step       (step),
		.debug_mode (debug_mode),
		.mem_addr   (mem_addr),
		.mem_read   (mem_read)
	);

	initial
		clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Processor and memory models
	//////////////////////////////////////////////////////////////////////

	// Core advances once per step pulse, new state shows the cycle after
	always @(negedge clk)
	begin
		if (step_seen)
			snapshot <= exp_snap;
		step_seen <= step;
		if (step)
		begin
			step_count = step_count + 1;
			exp_snap.pc          = 32'(step_count * 4);
			exp_snap.instruction = $random(seed);
			exp_snap.alu_result  = $random(seed);
			exp_snap.mem_data    = $random(seed);
		end
	end

	// Registered read, data follows one cycle after the strobe
	always @(negedge clk)
	begin
		if (read_pending)
			mem_rdata <= mem_words[read_addr];
		read_pending <= mem_read;
		read_addr    <= mem_addr;
	end

	always @(negedge clk)
	begin
		if (debug_mode)
			debug_cycles <= debug_cycles + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Checking and serial helpers
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("FAILED at %0t: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			rxd = frame[i];
			repeat (BIT_CLKS - 1) @(negedge clk);
		end
	endtask

	// Sample in the middle of each bit
	task automatic receive_byte(output logic [7:0] data);
		logic [7:0] bits;
		@(negedge clk);
		while (txd)
			@(negedge clk);
		repeat (BIT_CLKS / 2) @(negedge clk);
		check_value(32'(txd), 32'd0, "start bit on txd");
		for (int i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge clk);
			bits[i] = txd;
		end
		repeat (BIT_CLKS) @(negedge clk);
		data = bits;
		if (!txd)
			abort_run("Framing error: the stop bit on txd was low");
	endtask

	task automatic receive_bytes(input int count);
		logic [7:0] data;
		got_bytes.delete();
		repeat (count)
		begin
			receive_byte(data);
			got_bytes.push_back(data);
		end
	endtask

	function automatic logic [31:0] got_word(input int first);
		return {got_bytes[first + 3], got_bytes[first + 2],
			got_bytes[first + 1], got_bytes[first]};
	endfunction

	task automatic check_idle(input int bit_times, input string what);
		repeat (bit_times * BIT_CLKS)
		begin
			@(negedge clk);
			check_value(32'({txd, step, debug_mode, mem_read}), 32'b1000,
				$sformatf("txd, step, debug_mode, mem_read %s", what));
		end
	endtask

	task automatic check_dump(input string what);
		for (int w = 0; w < debug_pkg::MEM_DUMP_WORDS; w++)
			check_value(got_word(4 * w), mem_words[w], $sformatf("%s word %0d", what, w));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic run_step(input string what);
		int steps_before;
		steps_before = step_count;
		fork
			send_byte(debug_pkg::CMD_STEP);
			receive_bytes(debug_pkg::SNAPSHOT_BYTES);
		join
		check_value(32'(step_count - steps_before), 32'd1, {what, " step pulses"});
		check_value(got_word(0), exp_snap.pc, {what, " pc"});
		check_value(got_word(4), exp_snap.instruction, {what, " instruction"});
		check_value(got_word(8), exp_snap.alu_result, {what, " alu_result"});
		check_value(got_word(12), exp_snap.mem_data, {what, " mem_data"});
	endtask

	task automatic test_second_step();
		logic [31:0] pc_before;
		int          steps_before;
		pc_before = exp_snap.pc;
		run_step("second step");
		check_value(got_word(0), pc_before + 32'd4, "pc advance");
		steps_before = step_count;
		send_byte(8'h5A);
		check_idle(30, "after byte Z");
		check_value(32'(step_count - steps_before), 32'd0, "step pulses after byte Z");
	endtask

	task automatic test_mem_dump();
		int steps_before;
		int debug_before;
		steps_before = step_count;
		debug_before = debug_cycles;
		fork
			send_byte(debug_pkg::CMD_MEM_DUMP);
			receive_bytes(DUMP_BYTES);
		join
		check_value(32'(step_count - steps_before), 32'd0, "step pulses during dump");
		check_value(32'(debug_cycles > debug_before), 32'd1, "debug_mode raised by dump");
		check_value(32'(debug_mode), 32'd0, "debug_mode after dump");
		check_dump("dump");
		check_idle(2, "after dump");
	endtask

	task automatic test_step_during_dump();
		int steps_before;
		steps_before = step_count;
		fork
			begin
				send_byte(debug_pkg::CMD_MEM_DUMP);
				repeat (20 * BIT_CLKS) @(negedge clk);
				send_byte(debug_pkg::CMD_STEP);
			end
			receive_bytes(DUMP_BYTES);
		join
		check_idle(30, "after dump with step command");
		check_value(32'(step_count - steps_before), 32'd0, "step pulses during busy dump");
		check_dump("busy dump");
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("Timeout: the tests did not finish within the time limit");
	end

	initial
	begin
		rst_n = 1'b0;
		rxd   = 1'b1;
		for (int i = 0; i < debug_pkg::MEM_DUMP_WORDS; i++)
			mem_words[i] = $random(seed);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		check_idle(20, "after reset");
		run_step("first step");
		test_second_step();
		test_mem_dump();
		test_step_during_dump();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: project.f
source/debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/byte_fifo.sv
source/dump_sequencer.sv
source/uart_debug_unit.sv
bench/uart_debug_unit_sva.sv
bench/tb_uart_debug_unit.sv

// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := tb_uart_debug_unit
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported an error"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
